//--- hdl/ec_macros.svh
// ------------------------------------------------
// EC field constants
// Prime modulus, element width and Barrett factor
// ------------------------------------------------
`ifndef EC_MACROS_SVH
`define EC_MACROS_SVH

// Mersenne prime 2^31 - 1
`define EC_P 31'h7FFF_FFFF

// Bits per field element
`define EC_BITS 31

// floor(4^EC_BITS / EC_P), 33 bits
// Must be recomputed together with EC_P
`define EC_MU 33'h0_8000_0001

`endif

//--- hdl/fp_pkg.sv
// ------------------------------------------------
// Field arithmetic types for Fp
// Element, full product and multiplier tag
// ------------------------------------------------
`include "ec_macros.svh"

package fp_pkg;

  // One element of Fp, always below EC_P
  typedef logic [`EC_BITS-1:0] fp_t;

  // Unreduced product of two elements
  typedef logic [2*`EC_BITS-1:0] fp_prod_t;

  // Tag carried through the multiplier pipe
  // Wide enough for every equation id
  typedef logic [3:0] fp_tag_t;

endpackage

//--- hdl/ec_pkg.sv
// ------------------------------------------------
// Point doubling types
// Sequencer states, equation ids and constants
// ------------------------------------------------
`include "ec_macros.svh"

package ec_pkg;

  typedef enum logic [1:0] {
    ST_IDLE,                       // Waiting for a point
    ST_RUN,                        // Equations in progress
    ST_DONE                        // Result held for output
  } dbl_state_e;

  // Equation ids, also mask bit index and multiplier tag
  typedef enum logic [3:0] {
    EQ_A_SQ   = 4'd0,              // A = y*y
    EQ_B_MUL  = 4'd1,              // B = x*A
    EQ_B_X4   = 4'd2,              // B = 4*B
    EQ_C_SQ   = 4'd3,              // C = A*A
    EQ_C_X8   = 4'd4,              // C = 8*C
    EQ_D_SQ   = 4'd5,              // D = x*x
    EQ_D_X3   = 4'd6,              // D = 3*D
    EQ_X_SQ   = 4'd7,              // X = D*D
    EQ_E_X2   = 4'd8,              // E = 2*B, adder
    EQ_X_SUB  = 4'd9,              // X = X - E, adder
    EQ_Y_SUB  = 4'd10,             // Y = B - X, adder
    EQ_Y_MUL  = 4'd11,             // Y = D*Y
    EQ_Y_SUBC = 4'd12,             // Y = Y - C, adder
    EQ_Z_X2   = 4'd13,             // Z = 2*y, adder
    EQ_Z_MUL  = 4'd14              // Z = Z*z
  } dbl_eq_e;

  localparam int EQ_NUM = 15;

  // Small factors sent through the multiplier
  localparam logic [`EC_BITS-1:0] K3 = `EC_BITS'(3);
  localparam logic [`EC_BITS-1:0] K4 = `EC_BITS'(4);
  localparam logic [`EC_BITS-1:0] K8 = `EC_BITS'(8);

endpackage

//--- hdl/fp_mod_mult.sv
// ------------------------------------------------
// Pipelined modular multiplier over Fp
// Product, Barrett estimate, final correction
// Fixed 3 cycle latency, tag travels with data
// ------------------------------------------------
`include "ec_macros.svh"

module fp_mod_mult (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_val,
  input  fp_pkg::fp_t     i_a,
  input  fp_pkg::fp_t     i_b,
  input  fp_pkg::fp_tag_t i_tag,
  output logic            o_val,
  output fp_pkg::fp_t     o_dat,
  output fp_pkg::fp_tag_t o_tag
);
  import fp_pkg::*;

  localparam int K = `EC_BITS;

  // Stage 1 regs
  logic           s1_val;
  fp_prod_t       s1_prod;       // Full a*b
  fp_tag_t        s1_tag;

  // Stage 2 regs
  logic           s2_val;
  logic [K+1:0]   s2_rem;        // x - q*P, below 3P
  fp_tag_t        s2_tag;

  // Barrett datapath
  logic [K:0]     x_hi;          // x >> (K-1)
  logic [2*K+2:0] q_full;        // x_hi * mu
  logic [K+1:0]   q_est;         // Quotient estimate
  logic [2*K+1:0] qp_full;       // q_est * P
  logic [K+1:0]   rem;

  // Correction datapath
  logic [K+1:0]   r1;
  logic [K+1:0]   r2;

  always_comb begin
    x_hi    = s1_prod[2*K-1:K-1];
    q_full  = x_hi * `EC_MU;
    q_est   = q_full[2*K+2:K+1];  // Drop K+1 low bits
    qp_full = q_est * `EC_P;
    // Only the low K+2 bits matter, remainder is below 3P
    rem     = s1_prod[K+1:0] - qp_full[K+1:0];
  end

  // Estimate is short by at most two multiples of P
  always_comb begin
    r1 = (s2_rem >= `EC_P) ? s2_rem - `EC_P : s2_rem;
    r2 = (r1 >= `EC_P) ? r1 - `EC_P : r1;
  end

  // Valid bits
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      o_val  <= 1'b0;
    end else begin
      s1_val <= i_val;
      s2_val <= s1_val;
      o_val  <= s2_val;
    end
  end

  // Data and tags follow the valids
  always_ff @(posedge i_clk) begin
    s1_prod <= i_a * i_b;        // Full width product
    s1_tag  <= i_tag;
    s2_rem  <= rem;
    s2_tag  <= s1_tag;
    o_dat   <= r2[K-1:0];
    o_tag   <= s2_tag;
  end

endmodule

//--- hdl/ec_point_dbl.sv
// ------------------------------------------------
// Jacobian point doubling sequencer, a = 0
// Issues products as operands become ready,
// does adds and subtracts locally
// ------------------------------------------------
`include "ec_macros.svh"

module ec_point_dbl (
  input  logic            i_clk,
  input  logic            i_rst,
  // Point in
  input  fp_pkg::fp_t     i_x,
  input  fp_pkg::fp_t     i_y,
  input  fp_pkg::fp_t     i_z,
  input  logic            i_val,
  output logic            o_rdy,
  // Point out
  output fp_pkg::fp_t     o_x,
  output fp_pkg::fp_t     o_y,
  output fp_pkg::fp_t     o_z,
  output logic            o_val,
  input  logic            i_rdy,
  // Multiplier request
  output logic            o_mult_val,
  output fp_pkg::fp_t     o_mult_a,
  output fp_pkg::fp_t     o_mult_b,
  output fp_pkg::fp_tag_t o_mult_tag,
  // Multiplier response
  input  logic            i_res_val,
  input  fp_pkg::fp_t     i_res_dat,
  input  fp_pkg::fp_tag_t i_res_tag
);
  import fp_pkg::*;
  import ec_pkg::*;

  dbl_state_e        state;
  logic [EQ_NUM-1:0] eq_val;     // Result written
  logic [EQ_NUM-1:0] eq_wait;    // Issued or done

  // Latched input point
  fp_t pt_x;
  fp_t pt_y;
  fp_t pt_z;

  // Intermediates, o_x/o_y/o_z double as X/Y/Z
  fp_t a_r;
  fp_t b_r;
  fp_t c_r;
  fp_t d_r;
  fp_t e_r;

  logic    acc;                  // Point accepted this cycle
  logic    run;
  logic    iss_val;              // Multiply picked this cycle
  dbl_eq_e iss_eq;
  fp_t     iss_a;
  fp_t     iss_b;
  dbl_eq_e res_eq;

  // In-module add/sub enables
  logic do_e;
  logic do_xs;
  logic do_ys;
  logic do_yc;
  logic do_z;

  function automatic fp_t fp_add(input fp_t a, input fp_t b);
    logic [`EC_BITS:0] sum;
    sum = a + b;
    if (sum >= `EC_P)
      sum = sum - `EC_P;
    return sum[`EC_BITS-1:0];
  endfunction

  function automatic fp_t fp_sub(input fp_t a, input fp_t b);
    logic [`EC_BITS:0] dif;
    if (a >= b)
      dif = a - b;
    else
      dif = a + `EC_P - b;       // Wrap around the prime
    return dif[`EC_BITS-1:0];
  endfunction

  assign acc    = (state == ST_IDLE) && i_val && o_rdy;
  assign run    = (state == ST_RUN);
  assign res_eq = dbl_eq_e'(i_res_tag);

  // Pick one multiply per cycle, fixed priority
  // Long chains (A, D) go first to shorten the critical path
  always_comb begin
    iss_val = 1'b0;
    iss_eq  = EQ_A_SQ;
    iss_a   = pt_y;
    iss_b   = pt_y;
    if (!eq_wait[EQ_A_SQ]) begin
      iss_val = 1'b1;
    end else if (eq_val[EQ_A_SQ] && !eq_wait[EQ_B_MUL]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_B_MUL;
      iss_a   = pt_x;
      iss_b   = a_r;
    end else if (eq_val[EQ_A_SQ] && !eq_wait[EQ_C_SQ]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_C_SQ;
      iss_a   = a_r;
      iss_b   = a_r;
    end else if (!eq_wait[EQ_D_SQ]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_D_SQ;
      iss_a   = pt_x;
      iss_b   = pt_x;
    end else if (eq_val[EQ_D_SQ] && !eq_wait[EQ_D_X3]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_D_X3;
      iss_a   = K3;
      iss_b   = d_r;
    end else if (eq_val[EQ_D_X3] && !eq_wait[EQ_X_SQ]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_X_SQ;
      iss_a   = d_r;
      iss_b   = d_r;
    end else if (eq_val[EQ_Y_SUB] && eq_val[EQ_D_X3] && !eq_wait[EQ_Y_MUL]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_Y_MUL;
      iss_a   = d_r;
      iss_b   = o_y;
    end else if (eq_val[EQ_Z_X2] && !eq_wait[EQ_Z_MUL]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_Z_MUL;
      iss_a   = o_z;
      iss_b   = pt_z;
    end else if (eq_val[EQ_B_MUL] && !eq_wait[EQ_B_X4]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_B_X4;
      iss_a   = K4;
      iss_b   = b_r;
    end else if (eq_val[EQ_C_SQ] && !eq_wait[EQ_C_X8]) begin
      iss_val = 1'b1;
      iss_eq  = EQ_C_X8;
      iss_a   = K8;
      iss_b   = c_r;
    end
    if (!run)
      iss_val = 1'b0;            // Masks are stale outside RUN
  end

  // Add/sub equations, each fires once
  always_comb begin
    do_e  = run && eq_val[EQ_B_X4] && !eq_wait[EQ_E_X2];
    do_xs = run && eq_val[EQ_X_SQ] && eq_val[EQ_E_X2] && !eq_wait[EQ_X_SUB];
    do_ys = run && eq_val[EQ_X_SUB] && eq_val[EQ_B_X4] && !eq_wait[EQ_Y_SUB];
    do_yc = run && eq_val[EQ_Y_MUL] && eq_val[EQ_C_X8] && !eq_wait[EQ_Y_SUBC];
    do_z  = run && !eq_wait[EQ_Z_X2];
  end

  // Control FSM and masks
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= ST_IDLE;
      o_rdy      <= 1'b0;
      o_val      <= 1'b0;
      o_mult_val <= 1'b0;
      eq_val     <= '0;
      eq_wait    <= '0;
    end else begin
      o_mult_val <= iss_val;     // Multiplier has no ready
      case (state)
        ST_IDLE: begin
          o_rdy   <= 1'b1;
          eq_val  <= '0;
          eq_wait <= '0;
          if (acc) begin
            o_rdy <= 1'b0;
            if (i_z == '0) begin
              o_val <= 1'b1;     // Infinity passes straight through
              state <= ST_DONE;
            end else begin
              state <= ST_RUN;
            end
          end
        end
        ST_RUN: begin
          if (iss_val)
            eq_wait[iss_eq] <= 1'b1;
          if (i_res_val)
            eq_val[res_eq] <= 1'b1;
          if (do_e) begin
            eq_wait[EQ_E_X2] <= 1'b1;
            eq_val[EQ_E_X2]  <= 1'b1;
          end
          if (do_xs) begin
            eq_wait[EQ_X_SUB] <= 1'b1;
            eq_val[EQ_X_SUB]  <= 1'b1;
          end
          if (do_ys) begin
            eq_wait[EQ_Y_SUB] <= 1'b1;
            eq_val[EQ_Y_SUB]  <= 1'b1;
          end
          if (do_yc) begin
            eq_wait[EQ_Y_SUBC] <= 1'b1;
            eq_val[EQ_Y_SUBC]  <= 1'b1;
          end
          if (do_z) begin
            eq_wait[EQ_Z_X2] <= 1'b1;
            eq_val[EQ_Z_X2]  <= 1'b1;
          end
          if (&eq_val) begin
            o_val <= 1'b1;
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (i_rdy) begin       // Held until the sink takes it
            o_val <= 1'b0;
            o_rdy <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge i_clk) begin
    if (acc) begin
      pt_x <= i_x;
      pt_y <= i_y;
      pt_z <= i_z;
      if (i_z == '0) begin
        o_x <= i_x;
        o_y <= i_y;
        o_z <= i_z;
      end
    end
    if (iss_val) begin
      o_mult_a   <= iss_a;
      o_mult_b   <= iss_b;
      o_mult_tag <= fp_tag_t'(iss_eq);
    end
    // Results land by tag
    if (run && i_res_val) begin
      case (res_eq)
        EQ_A_SQ:  a_r <= i_res_dat;
        EQ_B_MUL: b_r <= i_res_dat;
        EQ_B_X4:  b_r <= i_res_dat;
        EQ_C_SQ:  c_r <= i_res_dat;
        EQ_C_X8:  c_r <= i_res_dat;
        EQ_D_SQ:  d_r <= i_res_dat;
        EQ_D_X3:  d_r <= i_res_dat;
        EQ_X_SQ:  o_x <= i_res_dat;
        EQ_Y_MUL: o_y <= i_res_dat;
        EQ_Z_MUL: o_z <= i_res_dat;
        default: ;
      endcase
    end
    if (do_e)
      e_r <= fp_add(b_r, b_r);   // 2B
    if (do_xs)
      o_x <= fp_sub(o_x, e_r);   // x3 = D^2 - 2B
    if (do_ys)
      o_y <= fp_sub(b_r, o_x);
    if (do_yc)
      o_y <= fp_sub(o_y, c_r);   // y3 done
    if (do_z)
      o_z <= fp_add(pt_y, pt_y);
  end

endmodule

//--- hdl/ec_dbl_top.sv
// ------------------------------------------------
// Point doubling top level
// Sequencer plus Barrett multiplier
// ------------------------------------------------
module ec_dbl_top (
  input  logic        i_clk,
  input  logic        i_rst,
  input  fp_pkg::fp_t i_x,
  input  fp_pkg::fp_t i_y,
  input  fp_pkg::fp_t i_z,
  input  logic        i_val,
  output logic        o_rdy,
  output fp_pkg::fp_t o_x,
  output fp_pkg::fp_t o_y,
  output fp_pkg::fp_t o_z,
  output logic        o_val,
  input  logic        i_rdy
);
  import fp_pkg::*;

  // Request side
  logic    mult_val;
  fp_t     mult_a;
  fp_t     mult_b;
  fp_tag_t mult_tag;
  // Response side, 3 cycles later
  logic    res_val;
  fp_t     res_dat;
  fp_tag_t res_tag;

  ec_point_dbl u_seq (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_x        (i_x),
    .i_y        (i_y),
    .i_z        (i_z),
    .i_val      (i_val),
    .o_rdy      (o_rdy),
    .o_x        (o_x),
    .o_y        (o_y),
    .o_z        (o_z),
    .o_val      (o_val),
    .i_rdy      (i_rdy),
    .o_mult_val (mult_val),
    .o_mult_a   (mult_a),
    .o_mult_b   (mult_b),
    .o_mult_tag (mult_tag),
    .i_res_val  (res_val),
    .i_res_dat  (res_dat),
    .i_res_tag  (res_tag)
  );

  fp_mod_mult u_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (mult_val),
    .i_a   (mult_a),
    .i_b   (mult_b),
    .i_tag (mult_tag),
    .o_val (res_val),
    .o_dat (res_dat),
    .o_tag (res_tag)
  );

endmodule

//--- bench/ec_dbl_sva.sv
// ------------------------------------------------
// Handshake assertions for the doubling top level
// ------------------------------------------------
module ec_dbl_sva (
  input logic        i_clk,
  input logic        i_rst,
  input logic        o_rdy,
  input logic        o_val,
  input logic        i_rdy,
  input fp_pkg::fp_t o_x,
  input fp_pkg::fp_t o_y,
  input fp_pkg::fp_t o_z
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;              // Assertion failures so far

  // Result must not move until the sink takes it
  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_x) && $stable(o_y) && $stable(o_z))
    else begin
      $error("Output point changed while the sink was stalled");
      fail_cnt++;
    end

  // Busy and done are exclusive
  a_rdy_val_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_rdy && o_val))
    else begin
      $error("o_rdy and o_val were high together");
      fail_cnt++;
    end

  a_rst_quiet: assert property (@(posedge i_clk) i_rst |=> !o_rdy && !o_val)
    else begin
      $error("o_rdy or o_val high after reset");
      fail_cnt++;
    end

endmodule

bind ec_dbl_top ec_dbl_sva u_sva (
  .i_clk (i_clk),
  .i_rst (i_rst),
  .o_rdy (o_rdy),
  .o_val (o_val),
  .i_rdy (i_rdy),
  .o_x   (o_x),
  .o_y   (o_y),
  .o_z   (o_z)
);

//--- bench/ec_dbl_model.svh
// ------------------------------------------------
// Reference model for point doubling checks
// Field ops mod EC_P and Jacobian doubling, a = 0
// ------------------------------------------------
`ifndef EC_DBL_MODEL_SVH
`define EC_DBL_MODEL_SVH

function automatic fp_pkg::fp_t add_mod(input fp_pkg::fp_t a, input fp_pkg::fp_t b);
  longint unsigned s;
  s = longint'(a) + longint'(b);
  return fp_pkg::fp_t'(s % `EC_P);
endfunction

// Adding P first keeps the difference positive
function automatic fp_pkg::fp_t sub_mod(input fp_pkg::fp_t a, input fp_pkg::fp_t b);
  longint unsigned s;
  s = longint'(a) + longint'(`EC_P) - longint'(b);
  return fp_pkg::fp_t'(s % `EC_P);
endfunction

function automatic fp_pkg::fp_t mul_mod(input fp_pkg::fp_t a, input fp_pkg::fp_t b);
  fp_pkg::fp_prod_t p;
  p = fp_pkg::fp_prod_t'(a) * fp_pkg::fp_prod_t'(b);
  return fp_pkg::fp_t'(p % `EC_P);
endfunction

function automatic void double_point(input fp_pkg::fp_t x, input fp_pkg::fp_t y,
                                     input fp_pkg::fp_t z, output fp_pkg::fp_t x3,
                                     output fp_pkg::fp_t y3, output fp_pkg::fp_t z3);
  fp_pkg::fp_t a;
  fp_pkg::fp_t b;
  fp_pkg::fp_t c;
  fp_pkg::fp_t d;
  a  = mul_mod(y, y);                          // A = y^2
  b  = mul_mod(mul_mod(x, a), 31'd4);          // B = 4xA
  c  = mul_mod(mul_mod(a, a), 31'd8);          // C = 8A^2
  d  = mul_mod(mul_mod(x, x), 31'd3);          // D = 3x^2
  x3 = sub_mod(mul_mod(d, d), add_mod(b, b));
  y3 = sub_mod(mul_mod(d, sub_mod(b, x3)), c);
  z3 = mul_mod(add_mod(y, y), z);
  if (z == '0) begin                           // Infinity comes back as is
    x3 = x;
    y3 = y;
    z3 = z;
  end
endfunction

`endif

//--- bench/ec_dbl_tb.sv
// ------------------------------------------------
// Testbench for the point doubling top level
// Table and random points checked against model
// ------------------------------------------------
`include "ec_macros.svh"

module ec_dbl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fp_pkg::*;

  `include "ec_dbl_model.svh"

  localparam fp_t P           = `EC_P;
  localparam int  N_FIX       = 9;               // Fixed table entries
  localparam int  N_RAND      = 20;
  localparam int  TIMEOUT_CYC = (N_FIX + N_RAND) * 80;

  logic i_clk;
  logic i_rst;
  fp_t  i_x;
  fp_t  i_y;
  fp_t  i_z;
  logic i_val;
  logic o_rdy;
  fp_t  o_x;
  fp_t  o_y;
  fp_t  o_z;
  logic o_val;
  logic i_rdy;

  // Stimulus table, one index per entry
  string q_name[$];
  fp_t   q_x[$];
  fp_t   q_y[$];
  fp_t   q_z[$];
  int    q_stall[$];

  int cyc_cnt = 0;

  ec_dbl_top u_dut (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_x   (i_x),
    .i_y   (i_y),
    .i_z   (i_z),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .o_x   (o_x),
    .o_y   (o_y),
    .o_z   (o_z),
    .o_val (o_val),
    .i_rdy (i_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;                  // 20 ns period
  end

  // Hard stop if a result never shows up
  always @(posedge i_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  // Bound handshake checker, first failure ends the run
  always @(posedge i_clk) begin
    if (u_dut.u_sva.fail_cnt != 0)
      stop_on_error("Failure: a handshake assertion in the bound checker fired");
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_val(input string name, input string what, input fp_t exp,
                           input fp_t act);
    assert (act == exp)
    else stop_on_error($sformatf("Error: %s %s expected %h actual %h",
                                 name, what, exp, act));
  endtask

  task automatic check_flag(input string name, input string what, input logic cond);
    assert (cond)
    else stop_on_error($sformatf("Failure in %s: %s did not hold", name, what));
  endtask

  task automatic add_entry(input string name, input fp_t x, input fp_t y, input fp_t z,
                           input int stall);
    q_name.push_back(name);
    q_x.push_back(x);
    q_y.push_back(y);
    q_z.push_back(z);
    q_stall.push_back(stall);
  endtask

  task automatic build_table();
    add_entry("small_z1",   31'd1, 31'd2, 31'd1, 0);
    add_entry("small_b",    31'd5, 31'd7, 31'd1, 2);
    add_entry("general_z",  31'h0123_4567, 31'h0765_4321, 31'h00AB_CDEF, 0);
    add_entry("general_z2", 31'h3ABC_1234, 31'h5DEF_0099, 31'h1357_9BDF, 1);
    add_entry("inf_z0",     31'h11, 31'h22, 31'd0, 1);
    add_entry("near_p",     P - 31'd1, P - 31'd2, P - 31'd1, 0);   // Barrett edge
    add_entry("near_p_b",   P - 31'd2, P - 31'd1, P - 31'd3, 3);
    add_entry("zero_y",     31'h77, 31'd0, 31'd5, 0);
    add_entry("long_stall", 31'd9, 31'd13, 31'd17, 12);
    for (int i = 0; i < N_RAND; i++) begin
      add_entry($sformatf("rand_%0d", i), fp_t'($urandom_range(P - 31'd1)),
                fp_t'($urandom_range(P - 31'd1)), fp_t'($urandom_range(P - 31'd1)),
                int'($urandom_range(6)));
    end
  endtask

  // One point through the DUT; called right after a rising edge
  task automatic run_entry(input int k);
    fp_t   ex;
    fp_t   ey;
    fp_t   ez;
    fp_t   hx;
    fp_t   hy;
    fp_t   hz;
    string nm;
    nm = q_name[k];
    double_point(q_x[k], q_y[k], q_z[k], ex, ey, ez);
    i_x   <= q_x[k];
    i_y   <= q_y[k];
    i_z   <= q_z[k];
    i_val <= 1'b1;
    do @(posedge i_clk); while (!o_rdy);         // Transfer on this edge
    i_x <= q_x[k] ^ 31'h155;                     // Decoy point while busy
    i_y <= q_y[k] ^ 31'h2AA;
    i_z <= q_z[k] ^ 31'h3;
    do begin
      @(posedge i_clk);
      check_flag(nm, "o_rdy low while busy", !o_rdy);
    end while (!o_val);
    i_val <= 1'b0;
    check_val(nm, "o_x", ex, o_x);
    check_val(nm, "o_y", ey, o_y);
    check_val(nm, "o_z", ez, o_z);
    hx = o_x;
    hy = o_y;
    hz = o_z;
    repeat (q_stall[k]) begin                    // Sink not ready yet
      @(posedge i_clk);
      check_flag(nm, "o_val held during stall", o_val);
      check_val(nm, "o_x held", hx, o_x);
      check_val(nm, "o_y held", hy, o_y);
      check_val(nm, "o_z held", hz, o_z);
    end
    i_rdy <= 1'b1;
    @(posedge i_clk);                            // Output taken here
    i_rdy <= 1'b0;
  endtask

  initial begin
    void'($urandom(46));
    i_rst = 1'b1;
    i_val = 1'b0;
    i_rdy = 1'b0;
    i_x   = '0;
    i_y   = '0;
    i_z   = '0;
    build_table();
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;
    for (int k = 0; k < q_name.size(); k++)
      run_entry(k);
    @(posedge i_clk);                            // Last edge's assertion results land
    if (u_dut.u_sva.fail_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "Handshake assertion failed");
    end
  end

endmodule

//--- flist.f
+incdir+hdl
+incdir+bench
hdl/fp_pkg.sv
hdl/ec_pkg.sv
hdl/fp_mod_mult.sv
hdl/ec_point_dbl.sv
hdl/ec_dbl_top.sv
bench/ec_dbl_sva.sv
bench/ec_dbl_tb.sv
